// File: filelist.f
+incdir+hw
hw/pbus_pkg.sv
hw/pbus_if.sv
hw/pbus_ctrl.sv
hw/gpio_port.sv
hw/sysid_timer.sv
hw/pbus_top.sv
tb/tb_pbus_top.sv

// File: tb/tb_pbus_top.sv
`include "pbus_settings.svh"

module tb_pbus_top import pbus_pkg::*;;
	timeunit 1ns;
	timeprecision 100ps;

	localparam addr_t A_OUT = {`PBUS_UNIT_GPIO, 4'h0};	// GPIO output data
	localparam addr_t A_OE = {`PBUS_UNIT_GPIO, 4'h1};	// GPIO output enable
	localparam addr_t A_SEL = {`PBUS_UNIT_GPIO, 4'h2};	// GPIO half select
	localparam addr_t A_INP = {`PBUS_UNIT_GPIO, 4'h3};	// GPIO input
	localparam addr_t A_CNT = {`PBUS_UNIT_SYS, 4'h3};	// Timer count
	localparam int RD_TIMEOUT = 20;	// Cycles to wait for rvalid

	logic clk;
	logic rst_n_i;
	logic bus_rd_i;
	logic bus_wr_i;
	addr_t bus_addr_i;
	data_t bus_wdata_i;
	data_t bus_rdata_o;
	logic bus_rvalid_o;
	pin_word_t port_in_i;
	pin_byte_t port_out_o;
	pin_byte_t port_oe_o;

	integer seed = 50578;
	pin_byte_t out_sh;	// Shadow of GPIO registers
	pin_byte_t oe_sh;
	pin_byte_t sel_sh;
	data_t tload_sh;	// Last timer load
	data_t rd_val;
	data_t rd_val2;
	data_t v;
	int gap;

	pbus_top dut0 (.*);

	always #4 clk = ~clk;	// 8 ns period

	task automatic fail_stop(input string what);
		$display("%s", what);
		$display("CHECKS FAILED");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check_data(input string name, input data_t exp, input data_t act);
		if (act !== exp)
			fail_stop($sformatf("ERROR %s expected %h got %h", name, exp, act));
	endtask

	task automatic check_pins(input string name, input pin_byte_t exp, input pin_byte_t act);
		if (act !== exp)
			fail_stop($sformatf("ERROR %s expected %h got %h", name, exp, act));
	endtask

	// Value must lie in base .. base+span, modulo 16 bits
	task automatic check_window(input string name, input data_t base, input data_t span,
			input data_t act);
		data_t d;
		d = act - base;
		if (d > span)
			fail_stop($sformatf("ERROR %s expected %h..%h got %h", name, base,
				data_t'(base + span), act));
	endtask

	// Expected read data from the register map
	function automatic data_t ref_read(input addr_t addr, input pin_byte_t out_r,
			input pin_byte_t oe_r, input pin_byte_t sel_r, input pin_word_t pins,
			input data_t tload);
		pin_byte_t inp;
		for (int k = 0; k < `GPIO_WIDTH; k++)
			inp[k] = sel_r[k] ? pins[k] : pins[k+`GPIO_WIDTH];	// 1 takes low half
		case (addr)
			A_OUT: return data_t'(out_r);
			A_OE: return data_t'(oe_r);
			A_SEL: return data_t'(sel_r);
			A_INP: return data_t'(inp);
			{`PBUS_UNIT_SYS, 4'h0}: return `SYS_IDCODE;
			{`PBUS_UNIT_SYS, 4'h1}: return `SYS_VERSNO;
			{`PBUS_UNIT_SYS, 4'h2}: return `SYS_FCPU_KHZ;
			A_CNT: return tload;	// Timer checked by window
			default: return '0;
		endcase
	endfunction

	// Called on a falling edge, returns on one
	task automatic bus_write(input addr_t addr, input data_t data);
		bus_addr_i = addr;
		bus_wdata_i = data;
		bus_wr_i = 1'b1;
		@(negedge clk);
		bus_wr_i = 1'b0;
	endtask

	task automatic bus_read(input addr_t addr, output data_t data);
		int waited;
		bus_addr_i = addr;
		bus_rd_i = 1'b1;
		@(negedge clk);
		bus_rd_i = 1'b0;
		waited = 0;
		while (!bus_rvalid_o && waited < RD_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (!bus_rvalid_o)
			fail_stop($sformatf("No read response arrived for address %h", addr));
		if (waited != 0)
			fail_stop($sformatf("Read response for address %h came %0d cycles late",
				addr, waited));
		data = bus_rdata_o;
	endtask

	task automatic check_read(input addr_t addr);
		data_t got;
		bus_read(addr, got);
		check_data($sformatf("bus_rdata_o@%h", addr),
			ref_read(addr, out_sh, oe_sh, sel_sh, port_in_i, tload_sh), got);
	endtask

	// rvalid must drop one cycle after the last response
	task automatic check_rvalid_idle();
		@(negedge clk);
		if (bus_rvalid_o !== 1'b0)
			fail_stop("Read response stayed valid for more than one cycle");
		check_data("bus_rdata_o", '0, bus_rdata_o);
	endtask

	initial begin
		clk = 1'b0;
		rst_n_i = 1'b0;
		bus_rd_i = 1'b0;
		bus_wr_i = 1'b0;
		bus_addr_i = '0;
		bus_wdata_i = '0;
		port_in_i = '0;
		out_sh = '0;	// Reset state of the port
		oe_sh = '0;
		sel_sh = '1;
		tload_sh = '0;
		repeat (4) @(negedge clk);
		rst_n_i = 1'b1;

		// Reset values and ID registers
		check_data("bus_rdata_o", '0, bus_rdata_o);
		check_pins("port_out_o", '0, port_out_o);
		check_pins("port_oe_o", '0, port_oe_o);
		for (int o = 0; o < 3; o++)
			check_read({`PBUS_UNIT_SYS, 4'(o)});
		check_read(A_SEL);

		// Output data and enable
		repeat (8) begin
			v = data_t'($random(seed));
			bus_write(A_OUT, v);
			out_sh = v[`GPIO_WIDTH-1:0];
			check_pins("port_out_o", out_sh, port_out_o);
			v = data_t'($random(seed));
			bus_write(A_OE, v);
			oe_sh = v[`GPIO_WIDTH-1:0];
			check_pins("port_oe_o", oe_sh, port_oe_o);
			check_read(A_OUT);
			check_read(A_OE);
		end

		// Input half select
		repeat (8) begin
			port_in_i = pin_word_t'($random(seed));
			v = data_t'($random(seed));
			bus_write(A_SEL, v);
			sel_sh = v[`GPIO_WIDTH-1:0];
			repeat (5) @(negedge clk);	// Past the synchronizer
			check_read(A_SEL);
			check_read(A_INP);
		end

		// Timer load and tick rate
		repeat (6) begin
			v = data_t'($random(seed));
			gap = ($random(seed) & 63);
			bus_write(A_CNT, v);
			tload_sh = v;
			bus_read(A_CNT, rd_val);
			check_window("bus_rdata_o timer", v, 16'd1, rd_val);
			repeat (gap) @(negedge clk);
			bus_read(A_CNT, rd_val2);	// Strobes gap+1 cycles apart
			check_window("bus_rdata_o timer delta",
				data_t'(rd_val + (gap + 1) / `SYS_TICK_DIV), 16'd1, rd_val2);
		end

		// Holes, unmapped units and back to back reads
		check_read(8'h07);
		check_read(8'h1a);
		check_read(8'h20);
		check_read(8'hf3);
		check_rvalid_idle();
		check_read({`PBUS_UNIT_SYS, 4'h0});
		check_read({`PBUS_UNIT_SYS, 4'h1});	// Next cycle strobe
		check_rvalid_idle();

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// File: hw/pbus_top.sv
module pbus_top import pbus_pkg::*; (
	input logic clk,
	input logic rst_n_i,
	input logic bus_rd_i,
	input logic bus_wr_i,
	input addr_t bus_addr_i,
	input data_t bus_wdata_i,
	output data_t bus_rdata_o,
	output logic bus_rvalid_o,
	input pin_word_t port_in_i,
	output pin_byte_t port_out_o,
	output pin_byte_t port_oe_o
);

	// One bus slice per unit
	pbus_if gpio_bus ();
	pbus_if sys_bus ();

	// Decode, strobes and read data merge
	pbus_ctrl ctrl0 (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.bus_rd_i(bus_rd_i),
		.bus_wr_i(bus_wr_i),
		.bus_addr_i(bus_addr_i),
		.bus_wdata_i(bus_wdata_i),
		.bus_rdata_o(bus_rdata_o),
		.bus_rvalid_o(bus_rvalid_o),
		.gpio_bus_o(gpio_bus.ctrl),
		.sys_bus_o(sys_bus.ctrl)
	);

	// Eight bit port, pins split into two input halves
	gpio_port gpio0 (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.bus_i(gpio_bus.unit),
		.port_in_i(port_in_i),
		.port_out_o(port_out_o),
		.port_oe_o(port_oe_o)
	);

	// ID registers and system timer
	sysid_timer sys0 (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.bus_i(sys_bus.unit)
	);

endmodule

// File: hw/sysid_timer.sv
`include "pbus_settings.svh"

module sysid_timer import pbus_pkg::*; (
	input logic clk,
	input logic rst_n_i,
	pbus_if.unit bus_i
);

	localparam ofs_t OFS_IDCODE = 4'h0;	// Product ID
	localparam ofs_t OFS_VERSNO = 4'h1;	// Version
	localparam ofs_t OFS_FCPU = 4'h2;	// Clock frequency
	localparam ofs_t OFS_COUNT = 4'h3;	// Timer count
	localparam int PRE_W = $clog2(`SYS_TICK_DIV);	// Prescaler width
	localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(`SYS_TICK_DIV - 1);

	logic [PRE_W-1:0] pre_q;	// Clock divider for ticks
	data_t count_q;	// Free running tick count
	logic load;	// Count write this cycle
	logic tick;	// Prescaler wraps

	assign load = bus_i.cs && bus_i.wr && (bus_i.ofs == OFS_COUNT);
	assign tick = (pre_q == PRE_LAST);

	// Prescaler and tick counter
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pre_q <= '0;
			count_q <= '0;
		end else if (load) begin
			pre_q <= '0;	// Full period before first tick
			count_q <= bus_i.wdata;
		end else if (tick) begin
			pre_q <= '0;
			count_q <= count_q + 1'b1;	// Wraps at 16 bits
		end else begin
			pre_q <= pre_q + 1'b1;
		end
	end

	// Registered read data, zero unless addressed
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			bus_i.rdata <= '0;
		end else if (bus_i.cs && bus_i.rd) begin
			case (bus_i.ofs)
				OFS_IDCODE: bus_i.rdata <= `SYS_IDCODE;
				OFS_VERSNO: bus_i.rdata <= `SYS_VERSNO;
				OFS_FCPU: bus_i.rdata <= `SYS_FCPU_KHZ;
				OFS_COUNT: bus_i.rdata <= count_q;
				default: bus_i.rdata <= '0;	// Unused offsets
			endcase
		end else begin
			bus_i.rdata <= '0;
		end
	end

	// Divider stays inside its period
	a_pre_range: assert property (
		@(posedge clk) disable iff (!rst_n_i)
		pre_q <= PRE_LAST
	);

endmodule

// File: hw/gpio_port.sv
`include "pbus_settings.svh"

module gpio_port import pbus_pkg::*; (
	input logic clk,
	input logic rst_n_i,
	pbus_if.unit bus_i,
	input pin_word_t port_in_i,
	output pin_byte_t port_out_o,
	output pin_byte_t port_oe_o
);

	localparam ofs_t OFS_OUT = 4'h0;	// Output data
	localparam ofs_t OFS_OE = 4'h1;	// Output enable
	localparam ofs_t OFS_SEL = 4'h2;	// Input half select
	localparam ofs_t OFS_INP = 4'h3;	// Selected input, read only

	pin_byte_t out_q;	// Output data register
	pin_byte_t oe_q;	// Output enable register
	pin_byte_t sel_q;	// 1 picks pin k, 0 picks pin k+8
	pin_word_t sync1_q;	// First synchronizer stage
	pin_word_t sync2_q;	// Second synchronizer stage
	pin_byte_t in_sel;	// Per bit half-selected input
	logic wr_en;
	logic rd_en;

	assign wr_en = bus_i.cs && bus_i.wr;
	assign rd_en = bus_i.cs && bus_i.rd;

	// Two flop synchronizer on both pin halves
	always_ff @(posedge clk) begin
		sync1_q <= port_in_i;
		sync2_q <= sync1_q;
	end

	// Mux after sync so a select write acts at once
	assign in_sel = (sel_q & sync2_q[`GPIO_WIDTH-1:0])
		| (~sel_q & sync2_q[2*`GPIO_WIDTH-1:`GPIO_WIDTH]);

	// Register writes
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			out_q <= '0;
			oe_q <= '0;	// Pins start hi-z
			sel_q <= '1;	// Low half on every bit
		end else if (wr_en) begin
			case (bus_i.ofs)
				OFS_OUT: out_q <= bus_i.wdata[`GPIO_WIDTH-1:0];
				OFS_OE: oe_q <= bus_i.wdata[`GPIO_WIDTH-1:0];
				OFS_SEL: sel_q <= bus_i.wdata[`GPIO_WIDTH-1:0];
				default: ;	// Input reg and holes ignore writes
			endcase
		end
	end

	// Registered read data, zero unless addressed
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			bus_i.rdata <= '0;
		end else if (rd_en) begin
			case (bus_i.ofs)
				OFS_OUT: bus_i.rdata <= data_t'(out_q);
				OFS_OE: bus_i.rdata <= data_t'(oe_q);
				OFS_SEL: bus_i.rdata <= data_t'(sel_q);
				OFS_INP: bus_i.rdata <= data_t'(in_sel);
				default: bus_i.rdata <= '0;
			endcase
		end else begin
			bus_i.rdata <= '0;
		end
	end

	assign port_out_o = out_q;
	assign port_oe_o = oe_q;

	// Unselected unit stays off the OR bus
	a_rdata_zero_no_cs: assert property (
		@(posedge clk) disable iff (!rst_n_i)
		!bus_i.cs |=> (bus_i.rdata == '0)
	);

endmodule

// File: hw/pbus_ctrl.sv
`include "pbus_settings.svh"

module pbus_ctrl import pbus_pkg::*; (
	input logic clk,
	input logic rst_n_i,
	input logic bus_rd_i,
	input logic bus_wr_i,
	input addr_t bus_addr_i,
	input data_t bus_wdata_i,
	output data_t bus_rdata_o,
	output logic bus_rvalid_o,
	pbus_if.ctrl gpio_bus_o,
	pbus_if.ctrl sys_bus_o
);

	logic [`PBUS_ADDR_W-`PBUS_OFS_W-1:0] unit_nib;	// Upper address part
	ofs_t ofs;	// Lower address part
	logic rvalid_q;	// Read strobe delayed by one cycle

	assign unit_nib = bus_addr_i[`PBUS_ADDR_W-1:`PBUS_OFS_W];
	assign ofs = bus_addr_i[`PBUS_OFS_W-1:0];

	// Chip selects, at most one active
	assign gpio_bus_o.cs = (unit_nib == `PBUS_UNIT_GPIO);
	assign sys_bus_o.cs = (unit_nib == `PBUS_UNIT_SYS);

	// Strobes and payload fan out to both units
	assign gpio_bus_o.rd = bus_rd_i;
	assign gpio_bus_o.wr = bus_wr_i;
	assign gpio_bus_o.ofs = ofs;
	assign gpio_bus_o.wdata = bus_wdata_i;
	assign sys_bus_o.rd = bus_rd_i;
	assign sys_bus_o.wr = bus_wr_i;
	assign sys_bus_o.ofs = ofs;
	assign sys_bus_o.wdata = bus_wdata_i;

	// Idle units return zero, so a plain OR merges them
	assign bus_rdata_o = gpio_bus_o.rdata | sys_bus_o.rdata;

	// Read response marker
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rvalid_q <= 1'b0;
		end else begin
			rvalid_q <= bus_rd_i;	// Unmapped reads still answer
		end
	end

	assign bus_rvalid_o = rvalid_q;

	// Master never issues both strobes in one cycle
	a_no_rd_wr: assert property (
		@(posedge clk) disable iff (!rst_n_i)
		!(bus_rd_i && bus_wr_i)
	);

	// Every read gets its response one cycle later
	a_rvalid_follows_rd: assert property (
		@(posedge clk) disable iff (!rst_n_i)
		bus_rd_i |=> bus_rvalid_o
	);

	// Read data quiet outside the response cycle
	a_rdata_quiet: assert property (
		@(posedge clk) disable iff (!rst_n_i)
		!bus_rvalid_o |-> (bus_rdata_o == '0)
	);

endmodule

// File: hw/pbus_if.sv
interface pbus_if import pbus_pkg::*;;

	logic cs;	// Unit selected by address decode
	logic rd;	// Read strobe, one cycle
	logic wr;	// Write strobe, one cycle
	ofs_t ofs;	// Register offset
	data_t wdata;	// Write data
	data_t rdata;	// Registered read data, zero when idle

	modport ctrl (
		output cs,
		output rd,
		output wr,
		output ofs,
		output wdata,
		input rdata
	);

	modport unit (
		input cs,
		input rd,
		input wr,
		input ofs,
		input wdata,
		output rdata
	);

endinterface

// File: hw/pbus_pkg.sv
`include "pbus_settings.svh"

package pbus_pkg;

	// Bus side
	typedef logic [`PBUS_ADDR_W-1:0] addr_t;	// Peripheral address
	typedef logic [`PBUS_DATA_W-1:0] data_t;	// Read and write data word
	typedef logic [`PBUS_OFS_W-1:0] ofs_t;	// Register offset in a unit

	// Pin side
	typedef logic [`GPIO_WIDTH-1:0] pin_byte_t;	// One port worth of pins
	typedef logic [2*`GPIO_WIDTH-1:0] pin_word_t;	// Low and high pin halves

endpackage

// File: hw/pbus_settings.svh
`ifndef PBUS_SETTINGS_SVH
`define PBUS_SETTINGS_SVH

// Bus geometry
`define PBUS_ADDR_W	8	// Byte address of the peripheral space
`define PBUS_DATA_W	16	// One bus word
`define PBUS_OFS_W	4	// Register offset inside a unit

// Unit map, upper address nibble
`define PBUS_UNIT_GPIO	4'h0	// GPIO port
`define PBUS_UNIT_SYS	4'h1	// ID registers and system timer

// ID register contents
`define SYS_IDCODE	16'h1170	// Product ID
`define SYS_VERSNO	16'h0148	// Version number
`define SYS_FCPU_KHZ	16'd24000	// Core clock in kHz

// System timer
`define SYS_TICK_DIV	8	// Clocks per timer tick

// GPIO
`define GPIO_WIDTH	8	// Pins per port

`endif
